/* verilog/du_cmd_pkg.sv */
// ==========================================================
// Host protocol definitions for the debug unit
// Byte type, command codes and reply codes
// ==========================================================

package du_cmd_pkg;

    typedef logic [7:0] uart_byte_t;  // One byte on the UART link

    // Command codes as one ASCII letter each
    localparam uart_byte_t CMD_LOAD = 8'h4C;  // 'L'
    localparam uart_byte_t CMD_RUN  = 8'h52;  // 'R'
    localparam uart_byte_t CMD_HALT = 8'h48;  // 'H'
    localparam uart_byte_t CMD_STEP = 8'h53;  // 'S'
    localparam uart_byte_t CMD_REGS = 8'h47;  // 'G'
    localparam uart_byte_t CMD_DMEM = 8'h4D;  // 'M'

    // Replies
    localparam uart_byte_t REPLY_ACK = 8'h06;
    localparam uart_byte_t REPLY_NAK = 8'h15;

    // Words travel as four bytes with the least significant first
    localparam int BYTES_PER_WORD = 4;

endpackage

/* verilog/du_cpu_pkg.sv */
// ==========================================================
// CPU side definitions seen by the debug unit
// ==========================================================

package du_cpu_pkg;

    typedef logic [31:0] pc_t;         // Program counter
    typedef logic [31:0] reg_t;        // Register file value
    typedef logic [31:0] instr_t;      // Instruction word
    typedef logic [7:0]  imem_addr_t;  // Instruction memory word address
    typedef logic [4:0]  reg_addr_t;   // Register index
    typedef logic [31:0] dmem_addr_t;  // Data memory byte address

    localparam int NUM_REGS = 32;

endpackage

/* verilog/du_master.sv */
// ==========================================================
// Debug unit command decoder and CPU run control
// Starts the execute blocks and requests ACK and NAK bytes
// ==========================================================

module du_master (
    input  logic                   clk,
    input  logic                   i_reset,
    input  du_cmd_pkg::uart_byte_t i_rx_data,
    input  logic                   i_rx_done,
    input  logic                   i_load_done,
    input  logic                   i_regs_done,
    input  logic                   i_dmem_done,
    input  logic                   i_tx_done_word,
    output logic                   o_cpu_en,
    output logic                   o_load_start,
    output logic                   o_regs_start,
    output logic                   o_dmem_start,
    output logic                   o_byte_req,
    output du_cmd_pkg::uart_byte_t o_byte
);
    import du_cmd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUNNING,  // CPU enabled and only halt decoded
        BUSY,     // Waiting for an execute block
        REPLY     // Waiting for ACK or NAK to go out
    } state_t;

    state_t state;
    logic   cmd_valid;

    // Start pulses share the cycle of the command byte, so the
    // started block is armed before the next byte can arrive
    assign cmd_valid    = (state == IDLE) && i_rx_done;
    assign o_load_start = cmd_valid && (i_rx_data == CMD_LOAD);
    assign o_regs_start = cmd_valid && (i_rx_data == CMD_REGS);
    assign o_dmem_start = cmd_valid && (i_rx_data == CMD_DMEM);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state      <= IDLE;
            o_cpu_en   <= 1'b0;
            o_byte_req <= 1'b0;
        end else begin
            o_byte_req <= 1'b0;
            case (state)
                IDLE: begin
                    o_cpu_en <= 1'b0;  // Ends a step after one cycle
                    if (i_rx_done) begin
                        case (i_rx_data)
                            CMD_LOAD, CMD_REGS, CMD_DMEM: state <= BUSY;
                            CMD_RUN: begin
                                o_cpu_en <= 1'b1;
                                state    <= RUNNING;
                            end
                            CMD_STEP: o_cpu_en <= 1'b1;
                            CMD_HALT: state <= IDLE;  // Already halted
                            default: begin
                                o_byte_req <= 1'b1;
                                o_byte     <= REPLY_NAK;
                                state      <= REPLY;
                            end
                        endcase
                    end
                end
                RUNNING: begin
                    if (i_rx_done && (i_rx_data == CMD_HALT)) begin
                        o_cpu_en <= 1'b0;
                        state    <= IDLE;
                    end
                end
                BUSY: begin
                    if (i_load_done) begin
                        o_byte_req <= 1'b1;  // Firmware load is acknowledged
                        o_byte     <= REPLY_ACK;
                        state      <= REPLY;
                    end else if (i_regs_done || i_dmem_done) begin
                        state <= IDLE;
                    end
                end
                REPLY: begin
                    if (i_tx_done_word)
                        state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* verilog/du_imem_loader.sv */
// ==========================================================
// Firmware loader
// Builds instructions from host bytes and writes imem
// ==========================================================

module du_imem_loader (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  du_cmd_pkg::uart_byte_t i_rx_data,
    input  logic                   i_rx_done,
    output logic                   o_done,
    output du_cpu_pkg::instr_t     o_imem_data,
    output du_cpu_pkg::imem_addr_t o_imem_waddr,
    output logic                   o_imem_wen
);
    import du_cmd_pkg::*;
    import du_cpu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        COUNT,  // Waiting for the instruction count
        DATA    // Shifting in instruction bytes
    } state_t;

    state_t     state;
    uart_byte_t words_left;
    logic [1:0] byte_cnt;     // Byte position inside the current word
    instr_t     instr_shift;

    assign o_imem_data = instr_shift;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state        <= IDLE;
            words_left   <= '0;
            byte_cnt     <= '0;
            o_imem_waddr <= '0;
            o_imem_wen   <= 1'b0;
            o_done       <= 1'b0;
        end else begin
            o_imem_wen <= 1'b0;
            o_done     <= o_imem_wen && (words_left == '0);  // Last word just written
            if (o_imem_wen)
                o_imem_waddr <= o_imem_waddr + 1'b1;
            case (state)
                IDLE: begin
                    if (i_start)
                        state <= COUNT;
                end
                COUNT: begin
                    if (i_rx_done) begin
                        words_left   <= i_rx_data;
                        byte_cnt     <= '0;
                        o_imem_waddr <= '0;  // Firmware starts at word 0
                        if (i_rx_data == '0) begin
                            o_done <= 1'b1;
                            state  <= IDLE;
                        end else begin
                            state <= DATA;
                        end
                    end
                end
                DATA: begin
                    if (i_rx_done) begin
                        instr_shift <= {i_rx_data, instr_shift[31:8]};  // LSB arrives first
                        byte_cnt    <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'(BYTES_PER_WORD - 1)) begin
                            o_imem_wen <= 1'b1;
                            words_left <= words_left - 1'b1;
                            if (words_left == 8'd1)
                                state <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* verilog/du_regfile_tx.sv */
// ==========================================================
// Register dump
// Sends the PC, then every register of the CPU
// ==========================================================

module du_regfile_tx (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_start,
    input  du_cpu_pkg::pc_t       i_pc,
    input  du_cpu_pkg::reg_t      i_regfile_data,
    input  logic                  i_tx_done_word,
    output logic                  o_done,
    output logic                  o_word_req,
    output du_cpu_pkg::reg_t      o_word,
    output logic                  o_regfile_rd,
    output du_cpu_pkg::reg_addr_t o_regfile_raddr
);
    import du_cpu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        SEND,   // Word is with the serializer
        READ,   // Read strobe is high
        LATCH   // Read data is valid
    } state_t;

    state_t state;
    logic   sending_pc;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state           <= IDLE;
            sending_pc      <= 1'b0;
            o_done          <= 1'b0;
            o_word_req      <= 1'b0;
            o_regfile_rd    <= 1'b0;
            o_regfile_raddr <= '0;
        end else begin
            o_done       <= 1'b0;
            o_word_req   <= 1'b0;
            o_regfile_rd <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_start) begin
                        o_word     <= i_pc;  // PC goes out first
                        o_word_req <= 1'b1;
                        sending_pc <= 1'b1;
                        state      <= SEND;
                    end
                end
                SEND: begin
                    if (i_tx_done_word) begin
                        if (sending_pc) begin
                            sending_pc      <= 1'b0;
                            o_regfile_raddr <= '0;
                            o_regfile_rd    <= 1'b1;
                            state           <= READ;
                        end else if (o_regfile_raddr == reg_addr_t'(NUM_REGS - 1)) begin
                            o_done <= 1'b1;
                            state  <= IDLE;
                        end else begin
                            o_regfile_raddr <= o_regfile_raddr + 1'b1;
                            o_regfile_rd    <= 1'b1;
                            state           <= READ;
                        end
                    end
                end
                READ: state <= LATCH;
                LATCH: begin
                    o_word     <= i_regfile_data;
                    o_word_req <= 1'b1;
                    state      <= SEND;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* verilog/du_dmem_tx.sv */
// ==========================================================
// Data memory dump
// Takes address and count from the host, sends the words
// ==========================================================

module du_dmem_tx (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  du_cmd_pkg::uart_byte_t i_rx_data,
    input  logic                   i_rx_done,
    input  du_cpu_pkg::reg_t       i_dmem_data,
    input  logic                   i_tx_done_word,
    output logic                   o_done,
    output logic                   o_word_req,
    output du_cpu_pkg::reg_t       o_word,
    output logic                   o_dmem_rd,
    output du_cpu_pkg::dmem_addr_t o_dmem_raddr
);
    import du_cmd_pkg::*;
    import du_cpu_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        ADDR,   // Collecting little endian address bytes
        COUNT,
        READ,
        LATCH,
        SEND
    } state_t;

    state_t     state;
    logic [1:0] byte_cnt;
    uart_byte_t words_left;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state        <= IDLE;
            byte_cnt     <= '0;
            words_left   <= '0;
            o_done       <= 1'b0;
            o_word_req   <= 1'b0;
            o_dmem_rd    <= 1'b0;
            o_dmem_raddr <= '0;
        end else begin
            o_done     <= 1'b0;
            o_word_req <= 1'b0;
            o_dmem_rd  <= 1'b0;
            case (state)
                IDLE: begin
                    byte_cnt <= '0;
                    if (i_start)
                        state <= ADDR;
                end
                ADDR: begin
                    if (i_rx_done) begin
                        o_dmem_raddr <= {i_rx_data, o_dmem_raddr[31:8]};
                        byte_cnt     <= byte_cnt + 1'b1;
                        if (byte_cnt == 2'(BYTES_PER_WORD - 1))
                            state <= COUNT;
                    end
                end
                COUNT: begin
                    if (i_rx_done) begin
                        words_left <= i_rx_data;
                        if (i_rx_data == '0) begin
                            o_done <= 1'b1;  // Empty dump
                            state  <= IDLE;
                        end else begin
                            o_dmem_rd <= 1'b1;
                            state     <= READ;
                        end
                    end
                end
                READ: state <= LATCH;  // Data arrives one cycle after the strobe
                LATCH: begin
                    o_word     <= i_dmem_data;
                    o_word_req <= 1'b1;
                    words_left <= words_left - 1'b1;
                    state      <= SEND;
                end
                SEND: begin
                    if (i_tx_done_word) begin
                        if (words_left == '0) begin
                            o_done <= 1'b1;
                            state  <= IDLE;
                        end else begin
                            o_dmem_raddr <= o_dmem_raddr + dmem_addr_t'(BYTES_PER_WORD);
                            o_dmem_rd    <= 1'b1;
                            state        <= READ;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* verilog/du_tx_serializer.sv */
// ==========================================================
// Reply serializer
// Splits words into bytes and paces them on i_tx_done
// ==========================================================

module du_tx_serializer (
    input  logic                   clk,
    input  logic                   i_reset,
    input  logic                   i_byte_req,
    input  du_cmd_pkg::uart_byte_t i_byte,
    input  logic                   i_regs_word_req,
    input  du_cpu_pkg::reg_t       i_regs_word,
    input  logic                   i_dmem_word_req,
    input  du_cpu_pkg::reg_t       i_dmem_word,
    input  logic                   i_tx_done,
    output logic                   o_wr,
    output du_cmd_pkg::uart_byte_t o_wdata,
    output logic                   o_tx_done_word
);
    import du_cmd_pkg::*;
    import du_cpu_pkg::*;

    reg_t       tx_shift;     // Current byte sits in the low bits
    logic [1:0] bytes_left;   // Bytes still to send after the current one
    logic       busy;

    assign o_wdata = tx_shift[7:0];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy           <= 1'b0;
            bytes_left     <= '0;
            o_wr           <= 1'b0;
            o_tx_done_word <= 1'b0;
        end else begin
            o_wr           <= 1'b0;
            o_tx_done_word <= 1'b0;
            if (!busy) begin
                if (i_byte_req || i_regs_word_req || i_dmem_word_req) begin
                    busy <= 1'b1;
                    o_wr <= 1'b1;
                end
                // Fixed priority of master then registers then data memory
                if (i_byte_req) begin
                    tx_shift   <= reg_t'(i_byte);
                    bytes_left <= '0;
                end else if (i_regs_word_req) begin
                    tx_shift   <= i_regs_word;
                    bytes_left <= 2'(BYTES_PER_WORD - 1);
                end else if (i_dmem_word_req) begin
                    tx_shift   <= i_dmem_word;
                    bytes_left <= 2'(BYTES_PER_WORD - 1);
                end
            end else if (i_tx_done) begin
                if (bytes_left == '0) begin
                    busy           <= 1'b0;
                    o_tx_done_word <= 1'b1;
                end else begin
                    tx_shift   <= {8'h00, tx_shift[31:8]};
                    bytes_left <= bytes_left - 1'b1;
                    o_wr       <= 1'b1;
                end
            end
        end
    end

endmodule

/* verilog/debug_unit_top.sv */
// ==========================================================
// Debug unit top level
// Decoder, execute blocks and reply serializer
// ==========================================================

module debug_unit_top (
    input  logic                   clk,
    input  logic                   i_reset,
    input  du_cpu_pkg::pc_t        i_pc,
    input  du_cpu_pkg::reg_t       i_regfile_data,
    input  du_cpu_pkg::reg_t       i_dmem_data,
    input  du_cmd_pkg::uart_byte_t i_rx_data,
    input  logic                   i_rx_done,
    input  logic                   i_tx_done,
    output logic                   o_cpu_en,
    output logic                   o_wr,
    output du_cmd_pkg::uart_byte_t o_wdata,
    output du_cpu_pkg::instr_t     o_imem_data,
    output du_cpu_pkg::imem_addr_t o_imem_waddr,
    output logic                   o_imem_wen,
    output logic                   o_regfile_rd,
    output du_cpu_pkg::reg_addr_t  o_regfile_raddr,
    output logic                   o_dmem_rd,
    output du_cpu_pkg::dmem_addr_t o_dmem_raddr
);
    import du_cmd_pkg::*;
    import du_cpu_pkg::*;

    logic       load_start, regs_start, dmem_start;
    logic       load_done, regs_done, dmem_done;
    logic       tx_done_word;                      // Fans out to every requester
    logic       master_byte_req;
    uart_byte_t master_byte;
    logic       regs_word_req, dmem_word_req;
    reg_t       regs_word, dmem_word;

    du_master u_du_master (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_rx_data      (i_rx_data),
        .i_rx_done      (i_rx_done),
        .i_load_done    (load_done),
        .i_regs_done    (regs_done),
        .i_dmem_done    (dmem_done),
        .i_tx_done_word (tx_done_word),
        .o_cpu_en       (o_cpu_en),
        .o_load_start   (load_start),
        .o_regs_start   (regs_start),
        .o_dmem_start   (dmem_start),
        .o_byte_req     (master_byte_req),
        .o_byte         (master_byte)
    );

    du_imem_loader u_du_imem_loader (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_start      (load_start),
        .i_rx_data    (i_rx_data),
        .i_rx_done    (i_rx_done),
        .o_done       (load_done),
        .o_imem_data  (o_imem_data),
        .o_imem_waddr (o_imem_waddr),
        .o_imem_wen   (o_imem_wen)
    );

    du_regfile_tx u_du_regfile_tx (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_start         (regs_start),
        .i_pc            (i_pc),
        .i_regfile_data  (i_regfile_data),
        .i_tx_done_word  (tx_done_word),
        .o_done          (regs_done),
        .o_word_req      (regs_word_req),
        .o_word          (regs_word),
        .o_regfile_rd    (o_regfile_rd),
        .o_regfile_raddr (o_regfile_raddr)
    );

    du_dmem_tx u_du_dmem_tx (
        .clk            (clk),
        .i_reset        (i_reset),
        .i_start        (dmem_start),
        .i_rx_data      (i_rx_data),
        .i_rx_done      (i_rx_done),
        .i_dmem_data    (i_dmem_data),
        .i_tx_done_word (tx_done_word),
        .o_done         (dmem_done),
        .o_word_req     (dmem_word_req),
        .o_word         (dmem_word),
        .o_dmem_rd      (o_dmem_rd),
        .o_dmem_raddr   (o_dmem_raddr)
    );

    // Single driver of the UART transmit lines
    du_tx_serializer u_du_tx_serializer (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_byte_req      (master_byte_req),
        .i_byte          (master_byte),
        .i_regs_word_req (regs_word_req),
        .i_regs_word     (regs_word),
        .i_dmem_word_req (dmem_word_req),
        .i_dmem_word     (dmem_word),
        .i_tx_done       (i_tx_done),
        .o_wr            (o_wr),
        .o_wdata         (o_wdata),
        .o_tx_done_word  (tx_done_word)
    );

endmodule

/* tb/tb_debug_unit_top.sv */
// ==========================================================
// Testbench for the debug unit top level
// Host and CPU models, reply scoreboard and checks
// ==========================================================

module tb_debug_unit_top;
    timeunit 1ns;
    timeprecision 100ps;

    import du_cmd_pkg::*;
    import du_cpu_pkg::*;

    localparam int TIMEOUT_CYCLES = 5000;

    logic       clk;
    logic       i_reset;
    pc_t        i_pc;
    reg_t       i_regfile_data;
    reg_t       i_dmem_data;
    uart_byte_t i_rx_data;
    logic       i_rx_done;
    logic       i_tx_done;
    logic       o_cpu_en;
    logic       o_wr;
    uart_byte_t o_wdata;
    instr_t     o_imem_data;
    imem_addr_t o_imem_waddr;
    logic       o_imem_wen;
    logic       o_regfile_rd;
    reg_addr_t  o_regfile_raddr;
    logic       o_dmem_rd;
    dmem_addr_t o_dmem_raddr;

    int         seed = 32'h6046;
    pc_t        pc_model;
    reg_t       regfile_model [NUM_REGS];
    reg_t       dmem_model [256];          // Indexed by address bits 9:2
    uart_byte_t rx_bytes [$];              // Bytes the DUT sent to the host
    int         tx_acks = 0;               // i_tx_done pulses given so far
    imem_addr_t imem_addr_q [$];
    instr_t     imem_data_q [$];
    int         strobe_count = 0;          // Any write or read strobe seen

    debug_unit_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % 32'(hi - lo + 1));
    endfunction

    function automatic logic [31:0] byte_of(input reg_t word, input int j);
        return 32'(word[8 * j +: 8]);
    endfunction

    task automatic send_byte(input uart_byte_t b);
        repeat (rand_range(1, 8)) @(posedge clk);
        i_rx_data <= b;
        i_rx_done <= 1'b1;
        @(posedge clk);
        i_rx_done <= 1'b0;
    endtask

    task automatic send_word(input logic [31:0] w);
        for (int j = 0; j < BYTES_PER_WORD; j++)
            send_byte(8'(w >> (8 * j)));  // Little endian
    endtask

    task automatic clear_replies();
        rx_bytes.delete();
        tx_acks = 0;
    endtask

    task automatic wait_replies(input int n, input string name);
        int cycles;
        cycles = 0;
        while (tx_acks < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                $display("Timeout: %s reply stopped after %0d of %0d bytes",
                         name, rx_bytes.size(), n);
                abort_run();
            end
        end
        repeat (4) @(posedge clk);  // Done pulses reach the decoder
        check({name, " byte count"}, 32'(n), 32'(rx_bytes.size()));
    endtask

    // Host side of the UART transmitter
    initial begin : tx_responder
        forever begin
            @(negedge clk);
            if (o_wr) begin
                rx_bytes.push_back(o_wdata);
                repeat (rand_range(1, 10)) @(posedge clk);
                i_tx_done <= 1'b1;
                @(posedge clk);
                i_tx_done <= 1'b0;
                tx_acks++;
            end
        end
    end

    // CPU memories with a read latency of one cycle
    initial begin : cpu_model
        logic       reg_rd;
        logic       mem_rd;
        reg_addr_t  reg_addr;
        dmem_addr_t mem_addr;
        forever begin
            @(negedge clk);
            reg_rd   = o_regfile_rd;
            reg_addr = o_regfile_raddr;
            mem_rd   = o_dmem_rd;
            mem_addr = o_dmem_raddr;
            if (o_imem_wen) begin
                imem_addr_q.push_back(o_imem_waddr);
                imem_data_q.push_back(o_imem_data);
            end
            if (o_wr || o_imem_wen || o_regfile_rd || o_dmem_rd)
                strobe_count++;
            @(posedge clk);
            if (reg_rd)
                i_regfile_data <= regfile_model[reg_addr];
            if (mem_rd)
                i_dmem_data <= dmem_model[mem_addr[9:2]];
        end
    end

    initial begin : main
        int         i;
        int         j;
        int         count;
        int         high;
        dmem_addr_t addr;
        reg_t       word;
        uart_byte_t b;
        instr_t     instrs [$];
        uart_byte_t run_cmds [3];

        run_cmds = '{CMD_LOAD, CMD_REGS, CMD_DMEM};
        pc_model = pc_t'($random(seed));
        for (i = 0; i < NUM_REGS; i++)
            regfile_model[i] = reg_t'($random(seed));
        for (i = 0; i < 256; i++)
            dmem_model[i] = reg_t'($random(seed));
        i_reset        <= 1'b1;
        i_pc           <= pc_model;
        i_regfile_data <= '0;
        i_dmem_data    <= '0;
        i_rx_data      <= '0;
        i_rx_done      <= 1'b0;
        i_tx_done      <= 1'b0;
        repeat (16) @(posedge clk);
        i_reset <= 1'b0;

        @(negedge clk);
        check("reset cpu_en", 32'd0, 32'(o_cpu_en));
        check("reset wr", 32'd0, 32'(o_wr));
        check("reset imem_wen", 32'd0, 32'(o_imem_wen));
        check("reset regfile_rd", 32'd0, 32'(o_regfile_rd));
        check("reset dmem_rd", 32'd0, 32'(o_dmem_rd));

        for (int round = 0; round < 3; round++) begin
            // Firmware load
            count = rand_range(0, 6);
            instrs.delete();
            imem_addr_q.delete();
            imem_data_q.delete();
            clear_replies();
            send_byte(CMD_LOAD);
            send_byte(8'(count));
            for (i = 0; i < count; i++) begin
                instrs.push_back(instr_t'($random(seed)));
                send_word(instrs[i]);
            end
            wait_replies(1, "load");
            check("load ack", 32'(REPLY_ACK), 32'(rx_bytes[0]));
            check("load write count", 32'(count), 32'(imem_data_q.size()));
            for (i = 0; i < count; i++) begin
                check("load address", 32'(i), 32'(imem_addr_q[i]));
                check("load data", instrs[i], imem_data_q[i]);
            end

            // PC then every register
            clear_replies();
            send_byte(CMD_REGS);
            wait_replies(BYTES_PER_WORD * (NUM_REGS + 1), "regs");
            for (i = 0; i <= NUM_REGS; i++) begin
                word = (i == 0) ? pc_model : regfile_model[i - 1];
                for (j = 0; j < BYTES_PER_WORD; j++)
                    check("regs byte", byte_of(word, j), 32'(rx_bytes[4 * i + j]));
            end

            // Data memory window
            addr  = dmem_addr_t'($random(seed)) & 32'hFFFF_FFFC;
            count = rand_range(0, 5);
            clear_replies();
            send_byte(CMD_DMEM);
            send_word(addr);
            send_byte(8'(count));
            wait_replies(BYTES_PER_WORD * count, "dmem");
            for (i = 0; i < count; i++) begin
                word = dmem_model[8'((addr >> 2) + dmem_addr_t'(i))];
                for (j = 0; j < BYTES_PER_WORD; j++)
                    check("dmem byte", byte_of(word, j), 32'(rx_bytes[4 * i + j]));
            end
        end

        // Single step, then run and halt
        clear_replies();
        send_byte(CMD_STEP);
        high = 0;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            if (i == 0)
                check("step enable", 32'd1, 32'(o_cpu_en));
            high += int'(o_cpu_en);
        end
        check("step cycles", 32'd1, 32'(high));
        send_byte(CMD_RUN);
        @(negedge clk);
        check("run enable", 32'd1, 32'(o_cpu_en));
        @(posedge clk);
        count = strobe_count;
        for (i = 0; i < 6; i++) begin
            b = (i < 3) ? run_cmds[i] : 8'($random(seed));
            if (b == CMD_HALT)
                b = CMD_STEP;
            send_byte(b);
            @(negedge clk);
            check("run enable held", 32'd1, 32'(o_cpu_en));
        end
        send_byte(CMD_HALT);
        @(negedge clk);
        check("halt enable", 32'd0, 32'(o_cpu_en));
        repeat (20) @(posedge clk);
        check("run replies", 32'd0, 32'(rx_bytes.size()));
        check("run strobes", 32'(count), 32'(strobe_count));

        // Unknown codes
        for (i = 0; i < 4; i++) begin
            b = 8'($random(seed));
            while (b inside {CMD_LOAD, CMD_RUN, CMD_HALT, CMD_STEP, CMD_REGS, CMD_DMEM})
                b = b + 8'd1;
            clear_replies();
            send_byte(b);
            wait_replies(1, "unknown");
            check("unknown nak", 32'(REPLY_NAK), 32'(rx_bytes[0]));
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

/* debug_unit_top.f */
verilog/du_cmd_pkg.sv
verilog/du_cpu_pkg.sv
verilog/du_master.sv
verilog/du_imem_loader.sv
verilog/du_regfile_tx.sv
verilog/du_dmem_tx.sv
verilog/du_tx_serializer.sv
verilog/debug_unit_top.sv
tb/tb_debug_unit_top.sv

/* Makefile */
# Verilator flow for the debug unit
VERILATOR ?= verilator
FILELIST  ?= debug_unit_top.f
TB_TOP    ?= tb_debug_unit_top
RTL_TOP   ?= debug_unit_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  ?= Done: no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TB_TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
